// ==== arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module arbiter
(
    input  logic               clk,
    input  logic               rst,

    input  logic               mem_read_in,
    input  logic               mem_write_in,
    input  lc3b_pkg::lc3b_word mem_address_fetch,
    input  lc3b_pkg::lc3b_word mem_address_mem,
    input  logic               mem_resp,

    output lc3b_pkg::lc3b_word mem_address,
    output logic               mem_read,
    output logic               mem_write,
    output logic               ld_regs
);

    typedef enum logic {
        data_phase,
        fetch_phase
    } state_t;

    state_t state;
    logic   resp_q;
    logic   data_pending;

    assign data_pending = (state == data_phase) && (mem_read_in || mem_write_in);

    // resp_q forces one idle cycle after every response
    always_comb begin
        if (data_pending) begin
            mem_address = mem_address_mem;
            mem_read    = mem_read_in && !resp_q;
            mem_write   = mem_write_in && !resp_q;
        end else begin
            mem_address = mem_address_fetch;
            mem_read    = !resp_q;
            mem_write   = 1'b0;
        end
    end

    assign ld_regs = mem_resp && !resp_q && !data_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= data_phase;
            resp_q <= 1'b0;
        end else begin
            resp_q <= mem_resp;
            if (ld_regs) begin
                state <= data_phase;
            end else if (data_pending && mem_resp && !resp_q) begin
                state <= fetch_phase;
            end
        end
    end

endmodule : arbiter

`default_nettype wire

// ==== decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load_regs,

    input  lc3b_pkg::lc3b_word         npc_in,
    input  lc3b_pkg::lc3b_word         ir_in,
    input  logic                       ld_reg_store,
    input  logic                       ld_cc_store,
    input  lc3b_pkg::lc3b_word         reg_data,
    input  lc3b_pkg::lc3b_reg          dest_reg,
    input  lc3b_pkg::lc3b_nzp          cc_data,

    output lc3b_pkg::lc3b_word         npc,
    output lc3b_pkg::lc3b_word         ir,
    output lc3b_pkg::lc3b_word         sr1,
    output lc3b_pkg::lc3b_word         sr2,
    output lc3b_pkg::lc3b_nzp          cc,
    output lc3b_pkg::lc3b_reg          dr,
    output lc3b_pkg::lc3b_control_word cw
);

    lc3b_pkg::lc3b_word         regs [lc3b_pkg::num_regs];
    lc3b_pkg::lc3b_nzp          cc_store;
    lc3b_pkg::lc3b_nzp          cc_now;
    lc3b_pkg::lc3b_opcode       opcode;
    lc3b_pkg::lc3b_control_word ctrl;
    lc3b_pkg::lc3b_reg          sr1_idx;
    lc3b_pkg::lc3b_reg          sr2_idx;
    lc3b_pkg::lc3b_word         sr1_val;
    lc3b_pkg::lc3b_word         sr2_val;

    assign opcode  = lc3b_pkg::lc3b_opcode'(ir_in[15:12]);
    assign sr1_idx = ir_in[8:6];
    // STR reads its source register from the dr field
    assign sr2_idx = (opcode == lc3b_pkg::op_str) ? ir_in[11:9] : ir_in[2:0];

    // write-back value is visible in the same cycle
    assign sr1_val = (ld_reg_store && dest_reg == sr1_idx) ? reg_data : regs[sr1_idx];
    assign sr2_val = (ld_reg_store && dest_reg == sr2_idx) ? reg_data : regs[sr2_idx];
    assign cc_now  = ld_cc_store ? cc_data : cc_store;

    always_ff @(posedge clk) begin
        if (load_regs && ld_reg_store) begin
            regs[dest_reg] <= reg_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cc_store <= '0;
        end else if (load_regs && ld_cc_store) begin
            cc_store <= cc_data;
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = opcode;
        case (opcode)
            lc3b_pkg::op_add: begin
                ctrl.aluop   = lc3b_pkg::alu_add;
                ctrl.imm_sel = ir_in[5];
                ctrl.ld_reg  = 1'b1;
                ctrl.ld_cc   = 1'b1;
            end
            lc3b_pkg::op_and: begin
                ctrl.aluop   = lc3b_pkg::alu_and;
                ctrl.imm_sel = ir_in[5];
                ctrl.ld_reg  = 1'b1;
                ctrl.ld_cc   = 1'b1;
            end
            lc3b_pkg::op_not: begin
                ctrl.aluop  = lc3b_pkg::alu_not;
                ctrl.ld_reg = 1'b1;
                ctrl.ld_cc  = 1'b1;
            end
            lc3b_pkg::op_ldr: begin
                ctrl.mem_read = 1'b1;
                ctrl.ld_reg   = 1'b1;
                ctrl.ld_cc    = 1'b1;
                ctrl.wb_mem   = 1'b1;
            end
            lc3b_pkg::op_str: begin
                ctrl.mem_write = 1'b1;
            end
            lc3b_pkg::op_br: begin
                ctrl.branch = 1'b1;
            end
            default: begin
                ctrl.aluop = lc3b_pkg::alu_pass;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= lc3b_pkg::nop_word;
            cw <= '0;
            dr <= '0;
            cc <= '0;
        end else if (load_regs) begin
            ir <= ir_in;
            cw <= ctrl;
            dr <= ir_in[11:9];
            cc <= cc_now;
        end
    end

    always_ff @(posedge clk) begin
        if (load_regs) begin
            npc <= npc_in;
            sr1 <= sr1_val;
            sr2 <= sr2_val;
        end
    end

endmodule : decode

`default_nettype wire

// ==== execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load_regs,

    input  lc3b_pkg::lc3b_word         npc_in,
    input  lc3b_pkg::lc3b_word         ir_in,
    input  lc3b_pkg::lc3b_word         sr1,
    input  lc3b_pkg::lc3b_word         sr2,
    input  lc3b_pkg::lc3b_nzp          cc_in,
    input  lc3b_pkg::lc3b_reg          dr_in,
    input  lc3b_pkg::lc3b_control_word cw_in,

    output lc3b_pkg::lc3b_word         address,
    output lc3b_pkg::lc3b_word         result,
    output lc3b_pkg::lc3b_word         npc,
    output lc3b_pkg::lc3b_word         ir,
    output lc3b_pkg::lc3b_word         data,
    output lc3b_pkg::lc3b_nzp          cc,
    output lc3b_pkg::lc3b_reg          dr,
    output lc3b_pkg::lc3b_control_word cw
);

    lc3b_pkg::lc3b_word imm5;
    lc3b_pkg::lc3b_word off6;
    lc3b_pkg::lc3b_word off9;
    lc3b_pkg::lc3b_word alu_b;
    lc3b_pkg::lc3b_word alu_out;
    lc3b_pkg::lc3b_word ea;

    assign imm5 = {{11{ir_in[4]}}, ir_in[4:0]};
    // offsets are word offsets, hence the extra zero
    assign off6 = {{9{ir_in[5]}}, ir_in[5:0], 1'b0};
    assign off9 = {{6{ir_in[8]}}, ir_in[8:0], 1'b0};

    assign alu_b = cw_in.imm_sel ? imm5 : sr2;

    always_comb begin
        case (cw_in.aluop)
            lc3b_pkg::alu_add: alu_out = sr1 + alu_b;
            lc3b_pkg::alu_and: alu_out = sr1 & alu_b;
            lc3b_pkg::alu_not: alu_out = ~sr1;
            default:           alu_out = alu_b;
        endcase
    end

    // branch target for BR, base plus offset for LDR and STR
    assign ea = cw_in.branch ? (npc_in + off9) : (sr1 + off6);

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= lc3b_pkg::nop_word;
            cw <= '0;
            cc <= '0;
            dr <= '0;
        end else if (load_regs) begin
            ir <= ir_in;
            cw <= cw_in;
            cc <= cc_in;
            dr <= dr_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load_regs) begin
            address <= ea;
            result  <= alu_out;
            npc     <= npc_in;
            data    <= sr2;
        end
    end

endmodule : execute

`default_nettype wire

// ==== fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch
(
    input  logic               clk,
    input  logic               rst,

    input  logic               pc_mux_sel,
    input  lc3b_pkg::lc3b_word target_pc,
    input  logic               ld_pc,
    input  lc3b_pkg::lc3b_word mem_rdata,

    output lc3b_pkg::lc3b_word inst_address,
    output lc3b_pkg::lc3b_word new_pc,
    output lc3b_pkg::lc3b_word ir
);

    lc3b_pkg::lc3b_word pc;
    lc3b_pkg::lc3b_word pc_plus2;

    assign inst_address = pc;
    assign pc_plus2     = pc + lc3b_pkg::pc_step;

    // taken branch from the memory stage overrides sequential fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= lc3b_pkg::reset_pc;
        end else if (ld_pc) begin
            pc <= pc_mux_sel ? target_pc : pc_plus2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= lc3b_pkg::nop_word;
        end else if (ld_pc) begin
            ir <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_pc) begin
            new_pc <= pc_plus2;
        end
    end

endmodule : fetch

`default_nettype wire

// ==== lc3b_pkg.sv ====
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;

    // only the opcodes this core executes
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // pass forwards the second operand
    typedef enum logic [1:0] {
        alu_pass = 2'b00,
        alu_add  = 2'b01,
        alu_and  = 2'b10,
        alu_not  = 2'b11
    } lc3b_aluop;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       imm_sel;
        logic       ld_reg;
        logic       ld_cc;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       wb_mem;
    } lc3b_control_word;

    // first fetch address
    localparam lc3b_word reset_pc = 16'h0000;

    // all-zero word decodes as a never-taken BR
    localparam lc3b_word nop_word = 16'h0000;

    localparam lc3b_word pc_step = 16'd2;

    localparam int num_regs = 8;

endpackage : lc3b_pkg

`default_nettype wire

// ==== mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load_regs,

    input  lc3b_pkg::lc3b_word         address_in,
    input  lc3b_pkg::lc3b_word         npc_in,
    input  lc3b_pkg::lc3b_word         ir_in,
    input  lc3b_pkg::lc3b_word         result_in,
    input  lc3b_pkg::lc3b_word         data_in,
    input  lc3b_pkg::lc3b_nzp          cc_in,
    input  lc3b_pkg::lc3b_reg          dr_in,
    input  lc3b_pkg::lc3b_control_word cw_in,

    input  lc3b_pkg::lc3b_word         mem_rdata,
    input  logic                       mem_resp,

    output lc3b_pkg::lc3b_word         mem_address,
    output lc3b_pkg::lc3b_word         mem_wdata,
    output logic                       mem_read,
    output logic                       mem_write,
    output logic                       mem_pc_mux,
    output lc3b_pkg::lc3b_word         target_pc,

    output lc3b_pkg::lc3b_word         result,
    output lc3b_pkg::lc3b_word         data,
    output lc3b_pkg::lc3b_reg          dr,
    output lc3b_pkg::lc3b_control_word cw
);

    lc3b_pkg::lc3b_word mdr;
    logic               capture;

    assign mem_address = address_in;
    assign mem_wdata   = data_in;
    assign mem_read    = cw_in.mem_read;
    assign mem_write   = cw_in.mem_write;

    // nzp field against the codes carried with the branch
    assign mem_pc_mux = cw_in.branch && (|(ir_in[11:9] & cc_in));
    assign target_pc  = mem_pc_mux ? address_in : npc_in;

    // the data response always comes before the fetch response of a step
    assign capture = mem_read && mem_resp && !load_regs;

    always_ff @(posedge clk) begin
        if (capture) begin
            mdr <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cw <= '0;
            dr <= '0;
        end else if (load_regs) begin
            cw <= cw_in;
            dr <= dr_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load_regs) begin
            result <= result_in;
            data   <= mdr;
        end
    end

endmodule : mem_access

`default_nettype wire

// ==== mp3.sv ====
`timescale 1ns/1ps
`default_nettype none

module mp3
(
    input  logic               clk,
    input  logic               rst,

    input  logic               mem_resp,
    input  lc3b_pkg::lc3b_word mem_rdata,
    output logic               mem_read,
    output logic               mem_write,
    output logic [1:0]         mem_byte_enable,
    output lc3b_pkg::lc3b_word mem_address,
    output lc3b_pkg::lc3b_word mem_wdata
);

    // shared pipeline strobe and feedback paths
    logic                       load_regs;
    logic                       pc_mux_sel;
    lc3b_pkg::lc3b_word         target_pc;
    lc3b_pkg::lc3b_word         pc_out;
    lc3b_pkg::lc3b_word         new_mem_address;
    logic                       new_mem_read;
    logic                       new_mem_write;
    lc3b_pkg::lc3b_word         reg_data;
    lc3b_pkg::lc3b_reg          dest_reg;
    logic                       ld_reg_store;
    logic                       ld_cc_store;
    lc3b_pkg::lc3b_nzp          gencc_out;

    lc3b_pkg::lc3b_word         f_de_npc;
    lc3b_pkg::lc3b_word         f_de_ir;

    lc3b_pkg::lc3b_word         de_ex_npc;
    lc3b_pkg::lc3b_word         de_ex_ir;
    lc3b_pkg::lc3b_word         de_ex_sr1;
    lc3b_pkg::lc3b_word         de_ex_sr2;
    lc3b_pkg::lc3b_nzp          de_ex_cc;
    lc3b_pkg::lc3b_reg          de_ex_dr;
    lc3b_pkg::lc3b_control_word de_ex_cw;

    lc3b_pkg::lc3b_word         ex_mem_address;
    lc3b_pkg::lc3b_word         ex_mem_result;
    lc3b_pkg::lc3b_word         ex_mem_npc;
    lc3b_pkg::lc3b_word         ex_mem_ir;
    lc3b_pkg::lc3b_word         ex_mem_data;
    lc3b_pkg::lc3b_nzp          ex_mem_cc;
    lc3b_pkg::lc3b_reg          ex_mem_dr;
    lc3b_pkg::lc3b_control_word ex_mem_cw;

    lc3b_pkg::lc3b_word         mem_wb_result;
    lc3b_pkg::lc3b_word         mem_wb_data;
    lc3b_pkg::lc3b_reg          mem_wb_dr;
    lc3b_pkg::lc3b_control_word mem_wb_cw;

    // word accesses only
    assign mem_byte_enable = 2'b11;

    arbiter arbiter_int
    (
        .clk,
        .rst,
        .mem_read_in(new_mem_read),
        .mem_write_in(new_mem_write),
        .mem_address_fetch(pc_out),
        .mem_address_mem(new_mem_address),
        .mem_resp,
        .mem_address,
        .mem_read,
        .mem_write,
        .ld_regs(load_regs)
    );

    fetch fetch_int
    (
        .clk,
        .rst,
        .pc_mux_sel,
        .target_pc,
        .ld_pc(load_regs),
        .mem_rdata,
        .inst_address(pc_out),
        .new_pc(f_de_npc),
        .ir(f_de_ir)
    );

    decode decode_int
    (
        .clk,
        .rst,
        .load_regs,
        .npc_in(f_de_npc),
        .ir_in(f_de_ir),
        .ld_reg_store,
        .ld_cc_store,
        .reg_data,
        .dest_reg,
        .cc_data(gencc_out),
        .npc(de_ex_npc),
        .ir(de_ex_ir),
        .sr1(de_ex_sr1),
        .sr2(de_ex_sr2),
        .cc(de_ex_cc),
        .dr(de_ex_dr),
        .cw(de_ex_cw)
    );

    execute execute_int
    (
        .clk,
        .rst,
        .load_regs,
        .npc_in(de_ex_npc),
        .ir_in(de_ex_ir),
        .sr1(de_ex_sr1),
        .sr2(de_ex_sr2),
        .cc_in(de_ex_cc),
        .dr_in(de_ex_dr),
        .cw_in(de_ex_cw),
        .address(ex_mem_address),
        .result(ex_mem_result),
        .npc(ex_mem_npc),
        .ir(ex_mem_ir),
        .data(ex_mem_data),
        .cc(ex_mem_cc),
        .dr(ex_mem_dr),
        .cw(ex_mem_cw)
    );

    mem_access mem_access_int
    (
        .clk,
        .rst,
        .load_regs,
        .address_in(ex_mem_address),
        .npc_in(ex_mem_npc),
        .ir_in(ex_mem_ir),
        .result_in(ex_mem_result),
        .data_in(ex_mem_data),
        .cc_in(ex_mem_cc),
        .dr_in(ex_mem_dr),
        .cw_in(ex_mem_cw),
        .mem_rdata,
        .mem_resp,
        .mem_address(new_mem_address),
        .mem_wdata,
        .mem_read(new_mem_read),
        .mem_write(new_mem_write),
        .mem_pc_mux(pc_mux_sel),
        .target_pc,
        .result(mem_wb_result),
        .data(mem_wb_data),
        .dr(mem_wb_dr),
        .cw(mem_wb_cw)
    );

    write_back write_back_int
    (
        .result(mem_wb_result),
        .data(mem_wb_data),
        .dr(mem_wb_dr),
        .cw(mem_wb_cw),
        .reg_data,
        .dest_reg,
        .ld_reg_store,
        .ld_cc_store,
        .gencc_out
    );

endmodule : mp3

`default_nettype wire

// ==== mp3_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mp3_sva
(
    input logic               clk,
    input logic               rst,
    input logic               mem_read,
    input logic               mem_write,
    input logic               mem_resp,
    input lc3b_pkg::lc3b_word mem_address,
    input lc3b_pkg::lc3b_word mem_wdata
);

    // first request out of reset is the fetch at reset_pc
    first_fetch: assert property (@(posedge clk)
        $fell(rst) |-> mem_read && !mem_write && mem_address == lc3b_pkg::reset_pc)
        else $error("first request after reset is not a read of reset_pc");

    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    request_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_read || mem_write) && !mem_resp |=>
            $stable(mem_address) && $stable(mem_read) && $stable(mem_write))
        else $error("request changed while waiting for mem_resp");

    wdata_stable: assert property (@(posedge clk) disable iff (rst)
        mem_write && !mem_resp |=> $stable(mem_wdata))
        else $error("write data changed while waiting for mem_resp");

    drop_after_resp: assert property (@(posedge clk) disable iff (rst)
        mem_resp |=> !mem_read && !mem_write)
        else $error("request still high in the cycle after mem_resp");

endmodule : mp3_sva

bind mp3 mp3_sva u_mp3_sva (
    .clk,
    .rst,
    .mem_read,
    .mem_write,
    .mem_resp,
    .mem_address,
    .mem_wdata
);

`default_nettype wire

// ==== mp3_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mp3_tb;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    logic               mem_resp = 1'b0;
    lc3b_pkg::lc3b_word mem_rdata = '0;
    logic               mem_read;
    logic               mem_write;
    logic [1:0]         mem_byte_enable;
    lc3b_pkg::lc3b_word mem_address;
    lc3b_pkg::lc3b_word mem_wdata;

    lc3b_pkg::lc3b_word mem [64];
    lc3b_pkg::lc3b_word exp_addr [11];
    lc3b_pkg::lc3b_word exp_data [11];
    string              test_name [4] = '{"ldr_str", "alu_ops", "br_not_taken", "br_taken"};
    int                 test_last [4] = '{0, 3, 6, 10};

    logic [31:0] lfsr = 32'hf3db_db7d;
    logic        busy = 1'b0;
    logic [1:0]  wait_left = '0;
    logic        marker_seen = 1'b0;
    int          store_idx = 0;
    int          test_idx = 0;
    int          test_errors = 0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycles;

    mp3 u_mp3 (
        .clk,
        .rst,
        .mem_resp,
        .mem_rdata,
        .mem_read,
        .mem_write,
        .mem_byte_enable,
        .mem_address,
        .mem_wdata
    );

    always #50 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic lc3b_pkg::lc3b_word enc_imm(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg d, input lc3b_pkg::lc3b_reg s, input logic [4:0] imm);
        return {op, d, s, 1'b1, imm};
    endfunction

    function automatic lc3b_pkg::lc3b_word enc_reg(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg d, input lc3b_pkg::lc3b_reg s1, input lc3b_pkg::lc3b_reg s2);
        return {op, d, s1, 3'b000, s2};
    endfunction

    function automatic lc3b_pkg::lc3b_word enc_mem(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg r, input lc3b_pkg::lc3b_reg b, input logic [5:0] off6);
        return {op, r, b, off6};
    endfunction

    function automatic lc3b_pkg::lc3b_word enc_br(input logic [2:0] nzp, input logic [8:0] off9);
        return {4'b0000, nzp, off9};
    endfunction

    task automatic draw_wait(output logic [1:0] w);
        w = '0;
        for (int i = 0; i < 2; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[0], lfsr[0]};
        end
    endtask

    task automatic load_program();
        lc3b_pkg::lc3b_word r1;
        lc3b_pkg::lc3b_word r2;
        lc3b_pkg::lc3b_word base;
        for (int i = 0; i < 64; i++) begin
            mem[i] = lc3b_pkg::nop_word;
        end
        mem[0]  = enc_imm(lc3b_pkg::op_and, 0, 0, 5'd0);
        mem[4]  = enc_mem(lc3b_pkg::op_ldr, 7, 0, 6'd31);
        mem[5]  = enc_imm(lc3b_pkg::op_add, 1, 0, 5'd7);
        mem[6]  = enc_imm(lc3b_pkg::op_add, 2, 0, 5'b11101);
        mem[8]  = enc_mem(lc3b_pkg::op_ldr, 6, 7, 6'd0);
        mem[9]  = enc_imm(lc3b_pkg::op_and, 4, 1, 5'd5);
        mem[10] = enc_reg(lc3b_pkg::op_add, 3, 1, 2);
        mem[11] = {4'b1001, 3'd5, 3'd1, 6'h3f};
        mem[12] = enc_mem(lc3b_pkg::op_str, 6, 7, 6'd1);
        mem[13] = enc_mem(lc3b_pkg::op_str, 4, 7, 6'd2);
        mem[14] = enc_mem(lc3b_pkg::op_str, 3, 7, 6'd3);
        mem[15] = enc_mem(lc3b_pkg::op_str, 5, 7, 6'd4);
        // BRz falls through while cc is negative
        // the three words after a branch always run
        mem[16] = enc_br(3'b010, 9'd5);
        mem[17] = enc_mem(lc3b_pkg::op_str, 1, 7, 6'd5);
        mem[18] = enc_mem(lc3b_pkg::op_str, 2, 7, 6'd6);
        mem[21] = enc_mem(lc3b_pkg::op_str, 1, 7, 6'd7);
        mem[22] = enc_br(3'b100, 9'd5);
        mem[23] = enc_mem(lc3b_pkg::op_str, 2, 7, 6'd8);
        mem[24] = enc_mem(lc3b_pkg::op_str, 3, 7, 6'd9);
        // skipped by the taken branch
        mem[27] = enc_mem(lc3b_pkg::op_str, 0, 7, 6'd10);
        mem[28] = enc_mem(lc3b_pkg::op_str, 4, 7, 6'd11);
        mem[30] = enc_mem(lc3b_pkg::op_str, 5, 7, 6'd31);
        mem[31] = 16'h0040;
        mem[32] = 16'hbeef;

        r1   = 16'd7;
        r2   = 16'hfffd;
        base = 16'h0040;
        exp_addr = '{base + 2, base + 4, base + 6, base + 8, base + 10, base + 12,
                     base + 14, base + 16, base + 18, base + 22, base + 62};
        exp_data = '{16'hbeef, r1 & 16'd5, r1 + r2, ~r1, r1, r2,
                     r1, r2, r1 + r2, r1 & 16'd5, ~r1};
    endtask

    task automatic check_store();
        if (store_idx >= 11) begin
            $display("unexpected store to %h after the last expected one", mem_address);
            errors++;
        end else begin
            assert (mem_address == exp_addr[store_idx]) else begin
                $display("ERROR %0t mem_address expected %h got %h",
                         $time, exp_addr[store_idx], mem_address);
                errors++;
                test_errors++;
            end
            assert (mem_wdata == exp_data[store_idx]) else begin
                $display("ERROR %0t mem_wdata expected %h got %h",
                         $time, exp_data[store_idx], mem_wdata);
                errors++;
                test_errors++;
            end
            // word stores only
            assert (mem_byte_enable == 2'b11) else begin
                $display("ERROR %0t mem_byte_enable expected %b got %b",
                         $time, 2'b11, mem_byte_enable);
                errors++;
                test_errors++;
            end
            if (store_idx == test_last[test_idx]) begin
                if (test_errors == 0) begin
                    $display("test %s: ok", test_name[test_idx]);
                    tests_passed++;
                end else begin
                    $display("test %s: %0d mismatches", test_name[test_idx], test_errors);
                    tests_failed++;
                end
                test_idx++;
                test_errors = 0;
            end
            store_idx++;
        end
        if (mem_address == 16'h007e) begin
            marker_seen = 1'b1;
        end
    endtask

    // memory model with 0 to 3 wait cycles per request
    always @(posedge clk) begin
        if (rst) begin
            mem_resp <= 1'b0;
            busy = 1'b0;
        end else begin
            mem_resp <= 1'b0;
            if (!mem_resp && (mem_read || mem_write)) begin
                if (!busy) begin
                    draw_wait(wait_left);
                    busy = 1'b1;
                end
                if (wait_left == 0) begin
                    busy = 1'b0;
                    mem_resp <= 1'b1;
                    if (mem_write) begin
                        check_store();
                        mem[mem_address[6:1]] <= mem_wdata;
                    end else begin
                        mem_rdata <= mem[mem_address[6:1]];
                    end
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    initial begin
        load_program();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (!marker_seen && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (!marker_seen) begin
            $display("timeout: the final store to the marker address never arrived");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed,
                     errors);
            if (errors == 0 && tests_failed == 0 && tests_passed == 4) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule : mp3_tb

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mp3_tb -f sim.f
./obj_dir/Vmp3_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    exit 1
fi
exit 0

// ==== sim.f ====
lc3b_pkg.sv
arbiter.sv
fetch.sv
decode.sv
execute.sv
mem_access.sv
write_back.sv
mp3.sv
mp3_sva.sv
mp3_tb.sv

// ==== write_back.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_back
(
    input  lc3b_pkg::lc3b_word         result,
    input  lc3b_pkg::lc3b_word         data,
    input  lc3b_pkg::lc3b_reg          dr,
    input  lc3b_pkg::lc3b_control_word cw,

    output lc3b_pkg::lc3b_word         reg_data,
    output lc3b_pkg::lc3b_reg          dest_reg,
    output logic                       ld_reg_store,
    output logic                       ld_cc_store,
    output lc3b_pkg::lc3b_nzp          gencc_out
);

    assign reg_data     = cw.wb_mem ? data : result;
    assign dest_reg     = dr;
    assign ld_reg_store = cw.ld_reg;
    assign ld_cc_store  = cw.ld_cc;

    // n z p from the value being written
    always_comb begin
        if (reg_data[15]) begin
            gencc_out = 3'b100;
        end else if (reg_data == '0) begin
            gencc_out = 3'b010;
        end else begin
            gencc_out = 3'b001;
        end
    end

endmodule : write_back

`default_nettype wire
